// ==== jram_pkg.sv ====
/* Banked work-RAM shared types
   Word, address, request and lane definitions */
package jram_pkg;

	// Data path width
	localparam int WORD_W = 16;

	// Word address width inside one bank
	localparam int BANK_AW = 9;

	// Bank select width at the top of the host address
	localparam int BANK_SW = 2;

	// Full host word address width
	localparam int HADDR_W = BANK_SW + BANK_AW;

	// Words per bank
	localparam int BANK_DEPTH = 1 << BANK_AW;

	// Largest bank count the host address can reach
	localparam int MAX_BANKS = 1 << BANK_SW;

	typedef logic [WORD_W-1:0]  word_t;     // Host and RAM data word
	typedef logic [BANK_AW-1:0] waddr_t;    // Word address within a bank
	typedef logic [HADDR_W-1:0] haddr_t;    // Host word address
	typedef logic [BANK_SW-1:0] bank_sel_t; // Bank index

	// One host request per cycle, idle when cen is high
	typedef struct packed {
		logic   cen;   // Chip enable, active low
		logic   rw;    // 1 read, 0 write
		haddr_t addr;  // Bank index in the top bits
		word_t  wdata; // Write data
	} jram_req_t;

	// What a single bank drives toward the resolver
	typedef struct packed {
		word_t             z_out; // Registered read word
		logic [WORD_W-1:0] z_oe;  // Per-bit output enable
	} jram_lane_t;

endpackage

// ==== jram_bank.sv ====
/* Work-RAM bank, 512 x 16 */
`timescale 1ns/1ps

module jram_bank (
	input  logic                 sys_clk,
	input  logic                 arst_n,
	input  logic                 cen,
	input  logic                 rw,
	input  jram_pkg::waddr_t     addr,
	input  jram_pkg::word_t      wdata,
	output jram_pkg::jram_lane_t lane
);
	import jram_pkg::*;

	// Storage array, contents undefined after reset
	word_t mem [BANK_DEPTH];

	word_t             rd_word; // Read word register, held between reads
	logic [WORD_W-1:0] oe_q;    // Output enable register
	logic              rd_en;
	logic              wr_en;

	assign rd_en = !cen && rw;  // Enabled read
	assign wr_en = !cen && !rw; // Enabled write

	// Write port
	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[addr] <= wdata; // Visible to a read in the next cycle
		end
	end

	// Registered read word and enables, one cycle after the request
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_word <= '0;
			oe_q    <= '0;
		end else begin
			if (rd_en) begin
				rd_word <= mem[addr];
				oe_q    <= '1; // Drive all bits for one cycle
			end else begin
				oe_q    <= '0; // Release on write or idle
			end
		end
	end

	// Enables work like the pad drivers of a tri-state pin
	assign lane.z_out = rd_word;
	assign lane.z_oe  = oe_q;

endmodule

// ==== jram_decode.sv ====
/* Host address decoder */
`timescale 1ns/1ps

module jram_decode #(
	parameter int NUM_BANKS = 3
) (
	input  logic                 sys_clk,
	input  logic                 arst_n,
	input  jram_pkg::jram_req_t  req,
	output logic [NUM_BANKS-1:0] bank_cen,
	output jram_pkg::waddr_t     bank_addr,
	output logic                 bank_rw,
	output jram_pkg::word_t      bank_wdata,
	output logic                 addr_err
);
	import jram_pkg::*;

	bank_sel_t            bank_sel;     // Upper host address bits
	logic [MAX_BANKS-1:0] sel_onehot;   // Active high select, all slots
	logic                 out_of_range; // Enabled access to an unfitted bank

	// Address split
	assign bank_sel   = req.addr[HADDR_W-1 -: BANK_SW];
	assign bank_addr  = req.addr[BANK_AW-1:0];

	// Shared by every bank
	assign bank_rw    = req.rw;
	assign bank_wdata = req.wdata;

	// One-hot select over every addressable slot
	always_comb begin
		sel_onehot = '0;
		if (!req.cen) begin
			sel_onehot[bank_sel] = 1'b1;
		end
	end

	// Only fitted banks get an enable
	assign bank_cen = ~sel_onehot[NUM_BANKS-1:0];

	// Slots at NUM_BANKS and above have no RAM behind them
	assign out_of_range = !req.cen && (int'(bank_sel) >= NUM_BANKS);

	// Error pulse lines up with the read data cycle
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			addr_err <= 1'b0;
		end else begin
			addr_err <= out_of_range;
		end
	end

endmodule

// ==== jram_resolve.sv ====
/* Bank lane resolver */
`timescale 1ns/1ps

module jram_resolve #(
	parameter int NUM_BANKS = 3
) (
	input  jram_pkg::jram_lane_t [NUM_BANKS-1:0] lanes,
	output jram_pkg::word_t                      rdata,
	output logic                                 rvalid,
	output logic                                 contention
);
	import jram_pkg::*;

	word_t             merged;   // AND-OR of all lanes
	logic [WORD_W-1:0] oe_seen;  // Bits driven by at least one lane
	logic [WORD_W-1:0] oe_clash; // Bits driven by two or more lanes

	// Stands in for the shared tri-state data bus
	always_comb begin
		merged   = '0;
		oe_seen  = '0;
		oe_clash = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			merged   = merged | (lanes[i].z_out & lanes[i].z_oe);
			oe_clash = oe_clash | (oe_seen & lanes[i].z_oe); // Already driven
			oe_seen  = oe_seen | lanes[i].z_oe;
		end
	end

	// Undriven bits read as zero
	assign rdata = merged;

	// Any bank on the bus
	assign rvalid = |oe_seen;

	// Two drivers on one bit, never expected from a correct decoder
	assign contention = |oe_clash;

endmodule

// ==== jram_sys.sv ====
/* Banked work-RAM subsystem top */
`timescale 1ns/1ps

module jram_sys #(
	parameter int NUM_BANKS = 3
) (
	input  logic                sys_clk,
	input  logic                arst_n,
	input  jram_pkg::jram_req_t req,
	output jram_pkg::word_t     rdata,
	output logic                rvalid,
	output logic                addr_err,
	output logic                contention
);
	import jram_pkg::*;

	logic [NUM_BANKS-1:0]         bank_cen;   // Per-bank enable, active low
	waddr_t                       bank_addr;  // Shared word address
	logic                         bank_rw;    // Shared read/write level
	word_t                        bank_wdata; // Shared write data
	jram_lane_t [NUM_BANKS-1:0]   lanes;      // One lane per fitted bank

	// Address decode and error flag
	jram_decode #(
		.NUM_BANKS  (NUM_BANKS)
	) u_decode (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.req        (req),
		.bank_cen   (bank_cen),
		.bank_addr  (bank_addr),
		.bank_rw    (bank_rw),
		.bank_wdata (bank_wdata),
		.addr_err   (addr_err)
	);

	// RAM banks
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		jram_bank u_bank (
			.sys_clk (sys_clk),
			.arst_n  (arst_n),
			.cen     (bank_cen[b]),
			.rw      (bank_rw),
			.addr    (bank_addr),
			.wdata   (bank_wdata),
			.lane    (lanes[b])
		);
	end

	// Lane merge onto the host read port
	jram_resolve #(
		.NUM_BANKS  (NUM_BANKS)
	) u_resolve (
		.lanes      (lanes),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.contention (contention)
	);

endmodule

// ==== jram_sva.sv ====
/* Read lane assertions */
`timescale 1ns/1ps

module jram_sva #(
	parameter int NUM_BANKS = 3
) (
	input logic                sys_clk,
	input logic                arst_n,
	input jram_pkg::jram_req_t req,
	input logic                rvalid,
	input logic                addr_err,
	input logic                contention
);
	import jram_pkg::*;

	bank_sel_t sel;
	logic      read_hit; // Enabled read of a fitted bank

	assign sel      = req.addr[HADDR_W-1 -: BANK_SW];
	assign read_hit = !req.cen && req.rw && (int'(sel) < NUM_BANKS);

	// Two banks on one bit
	a_no_contention: assert property (
		@(posedge sys_clk) disable iff (!arst_n) !contention
	) else $error("Read lane contention");

	a_read_valid: assert property (
		@(posedge sys_clk) disable iff (!arst_n) read_hit |=> rvalid
	) else $error("rvalid missing one cycle after a read");

	// Writes, idles and bad addresses leave the lane quiet
	a_no_stray_valid: assert property (
		@(posedge sys_clk) disable iff (!arst_n) !read_hit |=> !rvalid
	) else $error("rvalid without a read in the previous cycle");

	a_err_excludes_valid: assert property (
		@(posedge sys_clk) disable iff (!arst_n) !(addr_err && rvalid)
	) else $error("addr_err and rvalid high together");

endmodule

bind jram_sys jram_sva #(
	.NUM_BANKS  (NUM_BANKS)
) u_sva (
	.sys_clk    (sys_clk),
	.arst_n     (arst_n),
	.req        (req),
	.rvalid     (rvalid),
	.addr_err   (addr_err),
	.contention (contention)
);

// ==== jram_tb.sv ====
/* Banked work-RAM testbench */
`timescale 1ns/1ps

module jram_tb;
	import jram_pkg::*;

	localparam int NUM_BANKS = 3;
	localparam int CLK_HALF  = 4; // 8 ns period

	// One operation from the trace file
	typedef struct packed {
		logic [7:0] op;        // W, R or I
		haddr_t     addr;
		word_t      wdata;
		logic       exp_err;   // Error flag listed in the trace
		word_t      exp_rdata; // Read word listed in the trace
	} trace_op_t;

	logic      sys_clk;
	logic      arst_n;
	jram_req_t req;
	word_t     rdata;
	logic      rvalid;
	logic      addr_err;
	logic      contention;

	trace_op_t trace_q [$];
	word_t     shadow  [1 << HADDR_W]; // Reference memory by host address
	bit        written [1 << HADDR_W]; // Set once a word holds known data

	logic   exp_rvalid; // Response expected at the next falling edge
	logic   exp_err;
	word_t  exp_rdata;
	haddr_t exp_addr;

	int     check_errors;
	int     trace_errors;
	integer seed;
	bit     trace_loaded;

	jram_sys #(
		.NUM_BANKS  (NUM_BANKS)
	) u_jram_sys (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.req        (req),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.addr_err   (addr_err),
		.contention (contention)
	);

	initial begin
		sys_clk = 1'b0;
		forever #CLK_HALF sys_clk = ~sys_clk;
	end

	// Reads every operation into trace_q, returns 0 if the file is missing
	function automatic bit load_trace();
		int         fd;
		string      line;
		logic [7:0] op;
		haddr_t     addr;
		word_t      wdata;
		logic       err;
		word_t      rd;
		trace_op_t  ent;
		fd = $fopen("jram_trace.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue; // Blank or comment line
			end
			if ($sscanf(line, "%c %h %h %h %h", op, addr, wdata, err, rd) != 5) begin
				$display("Trace line could not be parsed: %s", line);
				trace_errors++;
			end else begin
				ent.op        = op;
				ent.addr      = addr;
				ent.wdata     = wdata;
				ent.exp_err   = err;
				ent.exp_rdata = rd;
				trace_q.push_back(ent);
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	// Compares the DUT outputs with the response predicted one cycle earlier
	task automatic check_outputs();
		word_t want;
		want = exp_rvalid ? exp_rdata : '0; // Nothing driven reads as zero
		assert (rvalid === exp_rvalid) else begin
			$display("CHECK FAILED @%0t: rvalid %b, expected %b", $time, rvalid, exp_rvalid);
			check_errors++;
		end
		assert (addr_err === exp_err) else begin
			$display("CHECK FAILED @%0t: addr_err %b, expected %b (address %h)",
				$time, addr_err, exp_err, exp_addr);
			check_errors++;
		end
		assert (contention === 1'b0) else begin
			$display("CHECK FAILED @%0t: contention is high", $time);
			check_errors++;
		end
		assert (rdata === want) else begin
			$display("CHECK FAILED @%0t: rdata %h, expected %h (address %h)",
				$time, rdata, want, exp_addr);
			check_errors++;
		end
	endtask

	// One request on a falling edge, then the model's prediction for it
	task automatic drive_request(input logic cen, input logic rw, input haddr_t addr,
		input word_t wdata);
		logic in_range;
		@(negedge sys_clk);
		check_outputs();
		req.cen    = cen;
		req.rw     = rw;
		req.addr   = addr;
		req.wdata  = wdata;
		in_range   = int'(addr[HADDR_W-1 -: BANK_SW]) < NUM_BANKS;
		exp_rvalid = !cen && rw && in_range;
		exp_err    = !cen && !in_range;
		exp_addr   = addr;
		if (exp_rvalid) begin
			exp_rdata = shadow[addr];
		end
		if (!cen && !rw && in_range) begin
			shadow[addr]  = wdata; // Unfitted banks keep nothing
			written[addr] = 1'b1;
		end
	endtask

	task automatic idle_cycle();
		drive_request(1'b1, 1'b0, '0, '0);
	endtask

	// Cross-checks the trace columns against the model, then drives the op
	task automatic apply_op(input trace_op_t t);
		logic in_range;
		logic want_err;
		in_range = int'(t.addr[HADDR_W-1 -: BANK_SW]) < NUM_BANKS;
		want_err = (t.op != "I") && !in_range;
		assert (t.exp_err === want_err) else begin
			$display("CHECK FAILED @%0t: trace error column %b for %h, model gives %b",
				$time, t.exp_err, t.addr, want_err);
			trace_errors++;
		end
		case (t.op)
			"W": drive_request(1'b0, 1'b0, t.addr, t.wdata);
			"R": begin
				if (in_range && !written[t.addr]) begin
					$display("Trace reads address %h before anything was written there",
						t.addr);
					trace_errors++;
				end else if (in_range) begin
					assert (t.exp_rdata === shadow[t.addr]) else begin
						$display("CHECK FAILED @%0t: trace expects %h at %h, model holds %h",
							$time, t.exp_rdata, t.addr, shadow[t.addr]);
						trace_errors++;
					end
				end
				drive_request(1'b0, 1'b1, t.addr, t.wdata);
			end
			"I": drive_request(1'b1, 1'b0, t.addr, t.wdata);
			default: begin
				$display("Unknown op code in trace: %c", t.op);
				trace_errors++;
			end
		endcase
	endtask

	initial begin
		int n_idle;
		seed         = 32'h8edd_5e07;
		check_errors = 0;
		trace_errors = 0;
		trace_loaded = 1'b0;
		exp_rvalid   = 1'b0; // Everything low right after reset
		exp_err      = 1'b0;
		exp_rdata    = '0;
		exp_addr     = '0;
		req          = '0;
		req.cen      = 1'b1;
		arst_n       = 1'b0;
		if (!load_trace()) begin
			$display("Could not open jram_trace.txt for reading");
			$display("=== FAIL ===");
			$finish;
		end else begin
			trace_loaded = 1'b1;
			repeat (3) @(posedge sys_clk);
			@(negedge sys_clk);
			arst_n = 1'b1;
			foreach (trace_q[i]) begin
				apply_op(trace_q[i]);
				n_idle = $unsigned($random(seed)) % 3; // 0 to 2 idle cycles
				repeat (n_idle) idle_cycle();
			end
			idle_cycle(); // Collects the last response
			$display("Errors: %0d in DUT checks, %0d in trace", check_errors, trace_errors);
			if (check_errors + trace_errors == 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
			$finish;
		end
	end

	// Watchdog, sized from the trace length
	initial begin
		wait (trace_loaded);
		repeat (trace_q.size() * 4 + 50) @(posedge sys_clk);
		$display("Run timed out: the trace did not finish within %0d clock periods",
			trace_q.size() * 4 + 50);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== jram_trace.txt ====
# op addr wdata exp_err exp_rdata   (op W write, R read, I idle)
# addr, wdata and exp_rdata in hex; exp_err is 1 for an unfitted bank
W 005 1234 0 0000
R 005 0000 0 1234
I 000 0000 0 0000
W 0a0 aaaa 0 0000
W 2a0 bbbb 0 0000
W 4a0 cccc 0 0000
R 0a0 0000 0 aaaa
R 2a0 0000 0 bbbb
R 4a0 0000 0 cccc
W 6a0 dead 1 0000
R 6a0 0000 1 0000
R 0a0 0000 0 aaaa
R 2a0 0000 0 bbbb
R 4a0 0000 0 cccc
R 7ff 0000 1 0000
I 000 0000 0 0000
W 000 0001 0 0000
W 200 0002 0 0000
W 400 0004 0 0000
W 1ff 0f0f 0 0000
W 3ff f0f0 0 0000
W 5ff 5a5a 0 0000
R 000 0000 0 0001
R 200 0000 0 0002
R 400 0000 0 0004
R 1ff 0000 0 0f0f
R 3ff 0000 0 f0f0
R 5ff 0000 0 5a5a
W 005 4321 0 0000
R 005 0000 0 4321
W 7a0 ffff 1 0000
R 0a0 0000 0 aaaa
R 5ff 0000 0 5a5a
R 000 0000 0 0001
I 000 0000 0 0000
R 2a0 0000 0 bbbb
R 4a0 0000 0 cccc
R 005 0000 0 4321

// ==== filelist.f ====
jram_pkg.sv
jram_bank.sv
jram_decode.sv
jram_resolve.sv
jram_sys.sv
jram_sva.sv
jram_tb.sv

// ==== Makefile ====
TOP := jram_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
